// ==== verification/lsu_patterns.mem ====
// op size uns base offset wdata flip_mask exp_data exp_err, all hex
// op 0 load 1 store; size 0 byte 1 half 2 word; err 0 none 1 corrected 2 double 3 misaligned 4 bus
1 2 0 f0040000 010 deadbeef 0 0 0
1 2 0 00001000 004 89abcdef 0 0 0
0 2 0 f0040000 010 0 0 deadbeef 0
0 0 0 f0040000 011 0 0 ffffffbe 0
0 0 1 f0040020 ff3 0 0 000000de 0
0 1 0 f0040000 012 0 0 ffffdead 0
0 1 1 f0040000 010 0 0 0000beef 0
1 0 0 00001000 005 00000077 0 0 0
1 0 0 f0040000 011 0000005a 0 0 0
1 1 0 f0040000 012 00001234 0 0 0
0 1 0 00001000 006 0 0 ffff89ab 0
0 2 0 f0040000 010 0 0 12345aef 0
0 2 0 00001000 004 0 0 89ab77ef 0
0 0 1 00001000 005 0 0 00000077 0
0 2 0 f0040000 010 0 4 12345aef 1
1 2 0 f0040020 000 cafef00d 0 0 0
0 2 0 f0040020 000 0 3 0 2
0 2 0 f0040000 012 0 0 0 3
1 1 0 f0040000 011 0000ffff 0 0 3
0 2 0 f0040000 010 0 0 12345aef 1
0 2 0 e0000000 000 0 0 0 4
1 2 0 e0000010 000 12345678 0 0 4
0 2 0 00001000 002 0 0 0 3
0 0 1 f0040000 010 0 0 000000ef 1

// ==== project.f ====
design/lsu_pkg.sv
design/lsu_if.sv
design/lsu_fifo.sv
design/lsu_addr_ctl.sv
design/lsu_dccm_ctl.sv
design/lsu_bus_ctl.sv
design/lsu_result_ord.sv
design/lsu_top.sv
verification/lsu_tb_mem.sv
verification/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/lsu_tb.sv ====
// LSU testbench: reads operation patterns, drives lsu_top, checks in-order responses
module lsu_tb import lsu_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          CLK_PERIOD   = 20;
   localparam int          RESET_CYCLES = 16;
   localparam int          NUM_PATS     = 24;             // Lines in the pattern file
   localparam int          PAT_FIELDS   = 9;
   localparam int          PAT_TIME     = 200;            // ns allowed per operation
   localparam logic [31:0] SEED         = 32'hfd61_0a27;

   typedef struct packed {
      logic [XLEN-1:0] data;
      lsu_err_e        err;
   } expect_t;

   // ******************************
   // DUT and memory signals
   // ******************************
   logic                    clk = 1'b0;
   logic                    rst_n;
   logic                    req_valid;
   logic                    req_ready;
   logic [XLEN-1:0]         req_base;
   logic [OFFSET_W-1:0]     req_offset;
   lsu_size_e               req_size;
   logic                    req_store;
   logic                    req_unsigned;
   logic [XLEN-1:0]         req_wdata;
   logic                    rsp_valid;
   logic                    rsp_ready = 1'b0;
   logic [XLEN-1:0]         rsp_data;
   lsu_err_e                rsp_err;
   logic                    dccm_rden;
   logic                    dccm_wren;
   logic [DCCM_ADDR_W-1:0]  dccm_addr;
   logic [DCCM_FDATA_W-1:0] dccm_wr_data;
   logic [DCCM_FDATA_W-1:0] dccm_rd_data;
   logic                    bus_req_valid;
   logic                    bus_req_ready;
   logic [XLEN-1:0]         bus_addr;
   logic                    bus_write;
   logic [XLEN-1:0]         bus_wdata;
   logic [STRB_W-1:0]       bus_wstrb;
   logic                    bus_rsp_valid;
   logic                    bus_rsp_err;
   logic [XLEN-1:0]         bus_rdata;
   logic                    flip_en;
   logic [DCCM_ADDR_W-1:0]  flip_addr;
   logic [DCCM_FDATA_W-1:0] flip_mask;
   logic [2:0]              stall_rnd = '0;   // Bus model ready and response stalls

   logic [63:0] pats [NUM_PATS*PAT_FIELDS];    // Nine fields per operation
   expect_t     exp_q [$];                     // Owed responses, oldest first
   logic [31:0] rng = SEED;
   int          issued_cnt  = 0;
   int          done_cnt    = 0;
   int          data_errs   = 0;
   int          status_errs = 0;
   int          proto_errs  = 0;

   lsu_top dut (.*);
   lsu_tb_mem mem_model (.*);

   always #(CLK_PERIOD/2) clk = ~clk;

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Random back-pressure, about one cycle in four held off
   always @(negedge clk) begin
      rng = next_random(rng);
      rsp_ready <= |rng[1:0];
      stall_rnd <= rng[6:4];
   end

   // ******************************
   // Checks
   // ******************************
   task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input int idx);
      if (got !== exp) begin
         $display("error at %0t ns: response %0d data %h, expected %h", $time, idx, got, exp);
         data_errs++;
      end
   endtask

   task automatic check_err(input lsu_err_e got, input lsu_err_e exp, input int idx);
      if (got !== exp) begin
         $display("error at %0t ns: response %0d status %s, expected %s",
                  $time, idx, got.name(), exp.name());
         status_errs++;
      end
   endtask

   // ******************************
   // Stimulus
   // ******************************
   task automatic issue_op(input int idx);
      logic [63:0]     f [PAT_FIELDS];
      logic [XLEN-1:0] ea;
      expect_t         exp;
      for (int k = 0; k < PAT_FIELDS; k++) f[k] = pats[idx*PAT_FIELDS + k];
      ea = f[3][XLEN-1:0] + {{(XLEN - OFFSET_W){f[4][OFFSET_W-1]}}, f[4][OFFSET_W-1:0]};
      exp.data = f[7][XLEN-1:0];
      exp.err  = lsu_err_e'(f[8][2:0]);
      @(negedge clk);
      if (f[6] != '0) begin
         // Drain first so no earlier access touches the flipped word
         req_valid <= 1'b0;
         while (done_cnt != issued_cnt) @(negedge clk);
         flip_en   <= 1'b1;
         flip_addr <= ea[DCCM_BITS-1:2];
         flip_mask <= f[6][DCCM_FDATA_W-1:0];
         @(negedge clk);
         flip_en   <= 1'b0;
      end
      req_valid    <= 1'b1;
      req_store    <= f[0][0];
      req_size     <= lsu_size_e'(f[1][1:0]);
      req_unsigned <= f[2][0];
      req_base     <= f[3][XLEN-1:0];
      req_offset   <= f[4][OFFSET_W-1:0];
      req_wdata    <= f[5][XLEN-1:0];
      exp_q.push_back(exp);
      issued_cnt++;
      @(posedge clk);
      while (!req_ready) @(posedge clk);   // Hold until the transfer
   endtask

   task automatic collect_rsps();
      expect_t exp;
      while (done_cnt < NUM_PATS) begin
         @(posedge clk);
         if (rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
               $display("Response at %0t ns arrived with no request outstanding", $time);
               proto_errs++;
            end else begin
               exp = exp_q.pop_front();
               // Data after a double error is not defined
               if (exp.err != ERR_ECC_DOUBLE) check_data(rsp_data, exp.data, done_cnt);
               check_err(rsp_err, exp.err, done_cnt);
            end
            done_cnt++;
         end
      end
   endtask

   initial begin
      rst_n        <= 1'b0;
      req_valid    <= 1'b0;
      req_base     <= '0;
      req_offset   <= '0;
      req_size     <= SZ_WORD;
      req_store    <= 1'b0;
      req_unsigned <= 1'b0;
      req_wdata    <= '0;
      flip_en      <= 1'b0;
      flip_addr    <= '0;
      flip_mask    <= '0;
      $readmemh("verification/lsu_patterns.mem", pats);
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n <= 1'b1;
      fork
         begin
            for (int i = 0; i < NUM_PATS; i++) issue_op(i);
            @(negedge clk);
            req_valid <= 1'b0;
         end
         collect_rsps();
      join
      @(negedge clk);
      $display("Summary: %0d data errors, %0d status errors, %0d protocol errors",
               data_errs, status_errs, proto_errs);
      if (data_errs == 0 && status_errs == 0 && proto_errs == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(RESET_CYCLES * CLK_PERIOD + NUM_PATS * PAT_TIME);
      $display("Timeout with %0d of %0d responses received", done_cnt, NUM_PATS);
      $display("Test failures found");
      $finish;
   end

endmodule

// ==== verification/lsu_tb_mem.sv ====
// Testbench memories: DCCM array with bit-flip injection and a stalling external bus memory
module lsu_tb_mem import lsu_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_n,
   // DCCM array
   input  logic                    dccm_rden,
   input  logic                    dccm_wren,
   input  logic [DCCM_ADDR_W-1:0]  dccm_addr,
   input  logic [DCCM_FDATA_W-1:0] dccm_wr_data,
   output logic [DCCM_FDATA_W-1:0] dccm_rd_data,
   input  logic                    flip_en,      // XOR flip_mask into one stored word
   input  logic [DCCM_ADDR_W-1:0]  flip_addr,
   input  logic [DCCM_FDATA_W-1:0] flip_mask,
   // External bus
   input  logic                    bus_req_valid,
   output logic                    bus_req_ready,
   input  logic [XLEN-1:0]         bus_addr,
   input  logic                    bus_write,
   input  logic [XLEN-1:0]         bus_wdata,
   input  logic [STRB_W-1:0]       bus_wstrb,
   output logic                    bus_rsp_valid,
   output logic                    bus_rsp_err,
   output logic [XLEN-1:0]         bus_rdata,
   input  logic [2:0]              stall_rnd     // Random bits from the testbench
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int         DCCM_WORDS = 2 ** DCCM_ADDR_W;
   localparam int         BUS_WORDS  = 256;
   localparam int         PEND_DEPTH = 8;
   localparam logic [3:0] ERR_REGION = 4'hE;     // 0xE000_0000 and up answers with error

   logic [DCCM_FDATA_W-1:0] dccm_arr [DCCM_WORDS] = '{default: '0};   // Valid codewords
   logic [XLEN-1:0]         bus_arr [BUS_WORDS] = '{default: '0};
   logic [XLEN-1:0]         pend_data [PEND_DEPTH];
   logic                    pend_err [PEND_DEPTH];
   logic [3:0]              push_cnt;
   logic [3:0]              pop_cnt;
   logic [3:0]              pop_next;
   logic [7:0]              bus_idx;
   logic                    err_hit;

   assign bus_idx = bus_addr[9:2];
   assign err_hit = (bus_addr[XLEN-1:XLEN-4] == ERR_REGION);

   function automatic logic [XLEN-1:0] merge_lanes(input logic [XLEN-1:0] old,
                                                   input logic [XLEN-1:0] wdata,
                                                   input logic [STRB_W-1:0] strb);
      logic [XLEN-1:0] w;
      w = old;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) w[8*b +: 8] = wdata[8*b +: 8];
      end
      return w;
   endfunction

   // ******************************
   // DCCM, read data one cycle after rden
   // ******************************
   always @(negedge clk) begin
      if (!rst_n) begin
         dccm_rd_data <= '0;
      end else begin
         if (flip_en) dccm_arr[flip_addr] <= dccm_arr[flip_addr] ^ flip_mask;
         if (dccm_wren) dccm_arr[dccm_addr] <= dccm_wr_data;
         if (dccm_rden) dccm_rd_data <= dccm_arr[dccm_addr];
      end
   end

   // ******************************
   // Bus memory, in-order responses
   // ******************************
   always @(posedge clk) begin
      if (!rst_n) begin
         push_cnt <= '0;
      end else if (bus_req_valid && bus_req_ready) begin
         if (bus_write && !err_hit) begin
            bus_arr[bus_idx] <= merge_lanes(bus_arr[bus_idx], bus_wdata, bus_wstrb);
         end
         pend_data[push_cnt[2:0]] <= err_hit ? '0 : bus_arr[bus_idx];   // Queue the answer
         pend_err[push_cnt[2:0]]  <= err_hit;
         push_cnt <= push_cnt + 4'd1;
      end
   end

   always @(negedge clk) begin
      if (!rst_n) begin
         pop_cnt       <= '0;
         bus_req_ready <= 1'b0;
         bus_rsp_valid <= 1'b0;
         bus_rsp_err   <= 1'b0;
         bus_rdata     <= '0;
      end else begin
         pop_next = pop_cnt + {3'b000, bus_rsp_valid};   // Taken at the last rising edge
         pop_cnt       <= pop_next;
         bus_req_ready <= |stall_rnd[1:0];
         bus_rsp_valid <= (push_cnt != pop_next) && stall_rnd[2];   // Random latency
         bus_rsp_err   <= pend_err[pop_next[2:0]];
         bus_rdata     <= pend_data[pop_next[2:0]];
      end
   end

endmodule

// ==== design/lsu_top.sv ====
// LSU top: address control, DCCM and bus paths, in-order result stage
module lsu_top import lsu_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_n,
   // Request
   input  logic                    req_valid,
   output logic                    req_ready,
   input  logic [XLEN-1:0]         req_base,
   input  logic [OFFSET_W-1:0]     req_offset,
   input  lsu_size_e               req_size,
   input  logic                    req_store,
   input  logic                    req_unsigned,
   input  logic [XLEN-1:0]         req_wdata,
   // Response
   output logic                    rsp_valid,
   input  logic                    rsp_ready,
   output logic [XLEN-1:0]         rsp_data,
   output lsu_err_e                rsp_err,
   // DCCM array
   output logic                    dccm_rden,
   output logic                    dccm_wren,
   output logic [DCCM_ADDR_W-1:0]  dccm_addr,
   output logic [DCCM_FDATA_W-1:0] dccm_wr_data,
   input  logic [DCCM_FDATA_W-1:0] dccm_rd_data,
   // External bus
   output logic                    bus_req_valid,
   input  logic                    bus_req_ready,
   output logic [XLEN-1:0]         bus_addr,
   output logic                    bus_write,
   output logic [XLEN-1:0]         bus_wdata,
   output logic [STRB_W-1:0]       bus_wstrb,
   input  logic                    bus_rsp_valid,
   input  logic                    bus_rsp_err,
   input  logic [XLEN-1:0]         bus_rdata
);
   logic ord_ready;

   lsu_req_if dccm_req ();
   lsu_req_if bus_req ();
   lsu_rsp_if dccm_rsp ();
   lsu_rsp_if bus_rsp ();

   lsu_addr_ctl u_addr_ctl (
      .req_valid, .req_ready, .req_base, .req_offset, .req_size,
      .req_store, .req_unsigned, .req_wdata, .ord_ready,
      .dccm_req(dccm_req.src), .bus_req(bus_req.src)
   );

   lsu_dccm_ctl u_dccm_ctl (
      .clk, .rst_n, .dccm_req(dccm_req.dst), .dccm_rsp(dccm_rsp.src),
      .dccm_rden, .dccm_wren, .dccm_addr, .dccm_wr_data, .dccm_rd_data
   );

   lsu_bus_ctl u_bus_ctl (
      .clk, .rst_n, .bus_req(bus_req.dst), .bus_rsp(bus_rsp.src),
      .bus_req_valid, .bus_req_ready, .bus_addr, .bus_write, .bus_wdata, .bus_wstrb,
      .bus_rsp_valid, .bus_rsp_err, .bus_rdata
   );

   lsu_result_ord u_result_ord (
      .clk, .rst_n, .dccm_mon(dccm_req.mon), .bus_mon(bus_req.mon),
      .dccm_rsp(dccm_rsp.dst), .bus_rsp(bus_rsp.dst), .ord_ready,
      .rsp_valid, .rsp_ready, .rsp_data, .rsp_err
   );

endmodule

// ==== design/lsu_result_ord.sv ====
// LSU result stage: tracks path of each accepted request, returns responses in order
module lsu_result_ord import lsu_pkg::*; (
   input  logic            clk,
   input  logic            rst_n,
   lsu_req_if.mon          dccm_mon,
   lsu_req_if.mon          bus_mon,
   lsu_rsp_if.dst          dccm_rsp,
   lsu_rsp_if.dst          bus_rsp,
   output logic            ord_ready,
   output logic            rsp_valid,
   input  logic            rsp_ready,
   output logic [XLEN-1:0] rsp_data,
   output lsu_err_e        rsp_err
);
   logic      dccm_acc;
   logic      bus_acc;
   logic      head_valid;
   lsu_path_e head_path;
   lsu_path_e acc_path;

   assign dccm_acc = dccm_mon.valid & dccm_mon.ready;
   assign bus_acc  = bus_mon.valid & bus_mon.ready;
   assign acc_path = bus_acc ? PATH_BUS : PATH_DCCM;

   lsu_fifo #(.T(lsu_path_e), .DEPTH(ORD_DEPTH)) u_ord_fifo (
      .clk, .rst_n,
      .push_valid(dccm_acc | bus_acc), .push_ready(ord_ready), .push_data(acc_path),
      .pop_valid(head_valid), .pop_ready(rsp_valid & rsp_ready), .pop_data(head_path)
   );

   // Only the head path may answer
   always_comb begin
      if (head_path == PATH_BUS) begin
         rsp_valid = head_valid & bus_rsp.valid;
         rsp_data  = bus_rsp.rsp.data;
         rsp_err   = bus_rsp.rsp.err;
      end else begin
         rsp_valid = head_valid & dccm_rsp.valid;
         rsp_data  = dccm_rsp.rsp.data;
         rsp_err   = dccm_rsp.rsp.err;
      end
   end

   assign dccm_rsp.ready = head_valid & (head_path == PATH_DCCM) & rsp_ready;
   assign bus_rsp.ready  = head_valid & (head_path == PATH_BUS) & rsp_ready;

endmodule

// ==== design/lsu_bus_ctl.sv ====
// LSU bus control: request issue under credits, load alignment, response queue
module lsu_bus_ctl import lsu_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   lsu_req_if.dst            bus_req,
   lsu_rsp_if.src            bus_rsp,
   output logic              bus_req_valid,
   input  logic              bus_req_ready,
   output logic [XLEN-1:0]   bus_addr,
   output logic              bus_write,
   output logic [XLEN-1:0]   bus_wdata,
   output logic [STRB_W-1:0] bus_wstrb,
   input  logic              bus_rsp_valid,   // No ready, credits reserve space
   input  logic              bus_rsp_err,
   input  logic [XLEN-1:0]   bus_rdata
);
   typedef struct packed {
      lsu_size_e  size;
      logic [1:0] byte_off;
      logic       uns;
      logic       store;
   } bus_meta_t;

   logic [BUS_CNT_W-1:0] out_cnt;   // Issued and not yet handed back
   logic       can_issue;
   logic       issue;
   logic       rsp_pop;
   logic       meta_ready;
   logic       meta_valid;
   logic       rsp_space;
   bus_meta_t  meta_in;
   bus_meta_t  meta_out;
   lsu_rsp_t   rsp_in;

   assign can_issue     = (out_cnt != BUS_CNT_W'(BUS_MAX_OUT)) & meta_ready;
   assign bus_req_valid = bus_req.valid & can_issue;
   assign bus_req.ready = bus_req_ready & can_issue;
   assign issue         = bus_req_valid & bus_req_ready;
   assign rsp_pop       = bus_rsp.valid & bus_rsp.ready;

   assign bus_addr  = {bus_req.req.addr[XLEN-1:2], bus_req.req.byte_off};
   assign bus_write = bus_req.req.store;
   assign bus_wdata = store_lanes(bus_req.req.wdata, bus_req.req.size);   // All lanes
   assign bus_wstrb = byte_strobe(bus_req.req.size, bus_req.req.byte_off);

   assign meta_in = '{size: bus_req.req.size, byte_off: bus_req.req.byte_off,
                      uns: bus_req.req.uns, store: bus_req.req.store};

   // Shape the returning word with the oldest request's size and offset
   assign rsp_in.data = (meta_out.store || bus_rsp_err) ? '0 :
                        load_align(bus_rdata, meta_out.byte_off, meta_out.size, meta_out.uns);
   assign rsp_in.err  = bus_rsp_err ? ERR_BUS : ERR_NONE;

   always_ff @(posedge clk) begin
      if (!rst_n) out_cnt <= '0;
      else        out_cnt <= out_cnt + BUS_CNT_W'(issue) - BUS_CNT_W'(rsp_pop);
   end

   lsu_fifo #(.T(bus_meta_t), .DEPTH(BUS_MAX_OUT)) u_meta_fifo (
      .clk, .rst_n,
      .push_valid(issue),         .push_ready(meta_ready), .push_data(meta_in),
      .pop_valid(meta_valid),     .pop_ready(bus_rsp_valid), .pop_data(meta_out)
   );

   lsu_fifo #(.T(lsu_rsp_t), .DEPTH(BUS_MAX_OUT)) u_rsp_fifo (
      .clk, .rst_n,
      .push_valid(bus_rsp_valid), .push_ready(rsp_space),  .push_data(rsp_in),
      .pop_valid(bus_rsp.valid),  .pop_ready(bus_rsp.ready), .pop_data(bus_rsp.rsp)
   );

   // External memory answers only what was issued
   a_rsp_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      bus_rsp_valid |-> meta_valid && rsp_space)
      else $error("lsu_bus_ctl: bus response with nothing outstanding");

endmodule

// ==== design/lsu_dccm_ctl.sv ====
// LSU DCCM control sequencing reads, merges and writes with SECDED on the array
module lsu_dccm_ctl import lsu_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_n,
   lsu_req_if.dst                  dccm_req,
   lsu_rsp_if.src                  dccm_rsp,
   output logic                    dccm_rden,
   output logic                    dccm_wren,
   output logic [DCCM_ADDR_W-1:0]  dccm_addr,
   output logic [DCCM_FDATA_W-1:0] dccm_wr_data,
   input  logic [DCCM_FDATA_W-1:0] dccm_rd_data   // One cycle after dccm_rden
);
   typedef enum logic [2:0] {ST_IDLE, ST_READ, ST_CHECK, ST_WRITE, ST_RESP} state_e;

   state_e          state;
   lsu_req_t        req_q;          // Accepted request
   logic [XLEN-1:0] wr_word;        // Word to encode on write
   lsu_rsp_t        rsp_q;
   ecc_dec_t        dec;
   lsu_err_e        ecc_err;
   logic [STRB_W-1:0] strb;
   logic [XLEN-1:0] bit_mask;

   assign dec     = ecc_decode(dccm_rd_data);
   assign ecc_err = dec.double_err ? ERR_ECC_DOUBLE :
                    dec.single_err ? ERR_ECC_CORR : ERR_NONE;
   assign strb    = byte_strobe(req_q.size, req_q.byte_off);

   always_comb begin
      for (int b = 0; b < STRB_W; b++) bit_mask[8*b +: 8] = {8{strb[b]}};
   end

   // ******************************
   // Sequencer
   // ******************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (dccm_req.valid) begin
                  if (dccm_req.req.fault) state <= ST_RESP;   // No memory access
                  else if (dccm_req.req.store && dccm_req.req.size == SZ_WORD) state <= ST_WRITE;
                  else state <= ST_READ;                      // Loads and sub-word RMW
               end
            end
            ST_READ:  state <= ST_CHECK;
            ST_CHECK: state <= (req_q.store && !dec.double_err) ? ST_WRITE : ST_RESP;
            ST_WRITE: state <= ST_RESP;
            ST_RESP:  if (dccm_rsp.ready) state <= ST_IDLE;
            default:  state <= ST_IDLE;
         endcase
      end
   end

   // Payload capture
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && dccm_req.valid) begin
         req_q      <= dccm_req.req;
         wr_word    <= dccm_req.req.wdata;
         rsp_q.data <= '0;
         rsp_q.err  <= dccm_req.req.fault ? ERR_MISALIGNED : ERR_NONE;
      end
      if (state == ST_CHECK) begin
         // Merge new lanes into the corrected word
         wr_word    <= (dec.data & ~bit_mask) | (store_lanes(req_q.wdata, req_q.size) & bit_mask);
         rsp_q.data <= req_q.store ? '0 :
                       load_align(dec.data, req_q.byte_off, req_q.size, req_q.uns);
         rsp_q.err  <= ecc_err;
      end
   end

   assign dccm_req.ready = (state == ST_IDLE);
   assign dccm_rsp.valid = (state == ST_RESP);
   assign dccm_rsp.rsp   = rsp_q;
   assign dccm_rden      = (state == ST_READ);
   assign dccm_wren      = (state == ST_WRITE);
   assign dccm_addr      = req_q.addr[DCCM_BITS-1:2];
   assign dccm_wr_data   = ecc_encode(wr_word);

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(dccm_rden && dccm_wren)) else $error("lsu_dccm_ctl: read and write together");

endmodule

// ==== design/lsu_addr_ctl.sv ====
// LSU address control: effective address, alignment check, region decode, path steering
module lsu_addr_ctl import lsu_pkg::*; (
   input  logic            req_valid,
   output logic            req_ready,
   input  logic [XLEN-1:0] req_base,
   input  logic [OFFSET_W-1:0] req_offset,
   input  lsu_size_e       req_size,
   input  logic            req_store,
   input  logic            req_unsigned,
   input  logic [XLEN-1:0] req_wdata,
   input  logic            ord_ready,     // Order FIFO has room
   lsu_req_if.src          dccm_req,
   lsu_req_if.src          bus_req
);
   logic [XLEN-1:0] ea;
   logic            misaligned;
   logic            in_dccm;
   logic            to_dccm;
   lsu_req_t        routed;

   // Base plus sign-extended offset
   assign ea = req_base + {{(XLEN - OFFSET_W){req_offset[OFFSET_W-1]}}, req_offset};

   assign misaligned = ((req_size == SZ_HALF) & ea[0]) |
                       ((req_size == SZ_WORD) & (|ea[1:0]));
   assign in_dccm = (ea[XLEN-1:DCCM_BITS] == DCCM_BASE[XLEN-1:DCCM_BITS]);
   assign to_dccm = in_dccm | misaligned;   // Faults always answered by DCCM path

   always_comb begin
      routed.addr     = {ea[XLEN-1:2], 2'b00};
      routed.byte_off = ea[1:0];
      routed.size     = req_size;
      routed.store    = req_store;
      routed.uns      = req_unsigned;
      routed.wdata    = req_wdata;
      routed.fault    = misaligned;
   end

   assign dccm_req.req   = routed;
   assign bus_req.req    = routed;
   assign dccm_req.valid = req_valid & ord_ready & to_dccm;   // Only with an order slot
   assign bus_req.valid  = req_valid & ord_ready & ~to_dccm;

   assign req_ready = ord_ready & (to_dccm ? dccm_req.ready : bus_req.ready);

   // One path per request
   always_comb begin
      a_one_path: assert (!(dccm_req.valid && bus_req.valid))
         else $error("lsu_addr_ctl: request steered to both paths");
   end

endmodule

// ==== design/lsu_fifo.sv ====
// Synchronous FIFO, circular buffer with count, payload type as parameter
module lsu_fifo #(
   parameter type T     = logic,
   parameter int  DEPTH = 2
) (
   input  logic clk,
   input  logic rst_n,
   input  logic push_valid,
   output logic push_ready,
   input  T     push_data,
   output logic pop_valid,
   input  logic pop_ready,
   output T     pop_data
);
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   T                 mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   assign push_ready = (count != CNT_W'(DEPTH));
   assign pop_valid  = (count != '0);
   assign pop_data   = mem[rd_ptr];               // Head, no read latency
   assign push       = push_valid & push_ready;
   assign pop        = pop_valid & pop_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + CNT_W'(push) - CNT_W'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= push_data;
   end

   // Producers size their traffic by credits or by ord_ready, so a full FIFO never sees a push
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      push_valid |-> push_ready) else $error("lsu_fifo: push while full");

endmodule

// ==== design/lsu_if.sv ====
// LSU internal handshakes: routed request and path response, valid/ready

// Request from address control to one path
interface lsu_req_if import lsu_pkg::*; ();
   logic     valid;
   logic     ready;
   lsu_req_t req;   // Held stable until the transfer

   modport src (
      output valid, req,
      input  ready
   );
   modport dst (
      input  valid, req,
      output ready
   );
   // Watches transfers only
   modport mon (
      input valid, ready
   );
endinterface

// Response from a path to the result stage
interface lsu_rsp_if import lsu_pkg::*; ();
   logic     valid;
   logic     ready;
   lsu_rsp_t rsp;

   modport src (
      output valid, rsp,
      input  ready
   );
   modport dst (
      input  valid, rsp,
      output ready
   );
endinterface

// ==== design/lsu_pkg.sv ====
// LSU package: widths, region map, request/response types and the SECDED ECC
package lsu_pkg;

   // ******************************
   // Widths and region map
   // ******************************
   localparam int XLEN         = 32;                   // Data and address width
   localparam int OFFSET_W     = 12;                   // Signed immediate offset
   localparam int STRB_W       = XLEN / 8;             // Byte lanes per word
   localparam logic [XLEN-1:0] DCCM_BASE = 32'hF004_0000;
   localparam int DCCM_BITS    = 16;                   // 64 KB of DCCM
   localparam int DCCM_ADDR_W  = DCCM_BITS - 2;        // Word index into the array
   localparam int ECC_W        = 7;                    // 6 Hamming bits plus overall parity
   localparam int DCCM_FDATA_W = XLEN + ECC_W;         // Stored word, ECC on top
   localparam int ORD_DEPTH    = 4;                    // In-order path FIFO
   localparam int BUS_MAX_OUT  = 2;                    // Outstanding bus requests
   localparam int BUS_CNT_W    = $clog2(BUS_MAX_OUT + 1);

   typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD} lsu_size_e;
   typedef enum logic {PATH_DCCM, PATH_BUS} lsu_path_e;
   typedef enum logic [2:0] {
      ERR_NONE, ERR_ECC_CORR, ERR_ECC_DOUBLE, ERR_MISALIGNED, ERR_BUS
   } lsu_err_e;

   typedef struct packed {
      logic [XLEN-1:0] addr;      // Word aligned, low two bits zero
      logic [1:0]      byte_off;  // Byte within the word
      lsu_size_e       size;
      logic            store;
      logic            uns;       // Zero-extend loads
      logic [XLEN-1:0] wdata;     // Store data, low aligned
      logic            fault;     // Misaligned, no memory access
   } lsu_req_t;

   typedef struct packed {
      logic [XLEN-1:0] data;      // Zero for stores
      lsu_err_e        err;
   } lsu_rsp_t;

   typedef struct packed {
      logic [XLEN-1:0] data;      // Corrected word
      logic            single_err;
      logic            double_err;
   } ecc_dec_t;

   // ******************************
   // Lane helpers
   // ******************************
   function automatic logic [STRB_W-1:0] byte_strobe(input lsu_size_e size, input logic [1:0] off);
      case (size)
         SZ_BYTE: return 4'b0001 << off;
         SZ_HALF: return 4'b0011 << off;
         default: return 4'b1111;
      endcase
   endfunction

   // Copy sub-word store data into every lane
   function automatic logic [XLEN-1:0] store_lanes(input logic [XLEN-1:0] wdata,
                                                   input lsu_size_e size);
      case (size)
         SZ_BYTE: return {4{wdata[7:0]}};
         SZ_HALF: return {2{wdata[15:0]}};
         default: return wdata;
      endcase
   endfunction

   // Pull addressed lanes down to bit 0 and extend
   function automatic logic [XLEN-1:0] load_align(input logic [XLEN-1:0] word,
                                                  input logic [1:0] off,
                                                  input lsu_size_e size, input logic uns);
      logic [XLEN-1:0] sh;
      sh = word >> {off, 3'b000};
      case (size)
         SZ_BYTE: return {{24{~uns & sh[7]}}, sh[7:0]};
         SZ_HALF: return {{16{~uns & sh[15]}}, sh[15:0]};
         default: return sh;
      endcase
   endfunction

   // ******************************
   // SECDED, Hamming positions 1..38
   // ******************************
   function automatic logic [DCCM_FDATA_W-1:0] ecc_encode(input logic [XLEN-1:0] data);
      logic [ECC_W-1:0] ecc;
      int j;
      ecc = '0;
      j = 0;
      for (int p = 1; p < DCCM_FDATA_W; p++) begin
         if ((p & (p - 1)) != 0) begin   // Data bits sit off the powers of two
            if (data[j]) ecc[5:0] ^= 6'(p);
            j++;
         end
      end
      ecc[ECC_W-1] = ^{ecc[5:0], data};  // Overall parity
      return {ecc, data};
   endfunction

   function automatic ecc_dec_t ecc_decode(input logic [DCCM_FDATA_W-1:0] fdata);
      ecc_dec_t res;
      logic [5:0] syn;
      logic parity;
      int j;
      res.data = fdata[XLEN-1:0];
      syn = fdata[XLEN +: 6];
      parity = ^fdata;                   // Odd count of flipped bits
      j = 0;
      for (int p = 1; p < DCCM_FDATA_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            if (fdata[j]) syn ^= 6'(p);
            j++;
         end
      end
      j = 0;
      for (int p = 1; p < DCCM_FDATA_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            if (parity && syn == 6'(p)) res.data[j] = ~res.data[j];  // Fix the data bit
            j++;
         end
      end
      res.single_err = parity;           // Includes a flip of a check bit
      res.double_err = !parity && (syn != '0);
      return res;
   endfunction

endpackage
